// File: apb_mem_port.sv
// apb write slave with address decode into memory write strobes
`timescale 1ns/10ps
`default_nettype none

module apb_mem_port (
    input  logic              clk_sys,
    input  logic              reset,
    input  bus_pkg::apb_req_t apb,
    input  logic              copy_busy,
    output logic              pready,
    output logic              pslverr,
    output logic              attr_we,
    output logic              bank_we,
    output logic              gfx_we,
    output logic [15:0]       waddr,
    output logic [7:0]        wdata
);
    import bus_pkg::*;

    logic      setup;
    logic      access;
    logic      done;
    logic      attr_hit;
    logic      bank_hit;
    logic      gfx_hit;
    logic      attr_sel;
    logic      bank_sel;
    logic      gfx_sel;
    logic      bad_sel;
    apb_addr_t offset;

    function automatic logic in_region(apb_addr_t addr, int unsigned base, int unsigned size);
        return (32'(addr) >= base) && (32'(addr) < base + size);
    endfunction

    assign setup  = apb.psel && !apb.penable;
    assign access = apb.psel && apb.penable;

    always_comb begin
        attr_hit = in_region(apb.paddr, ATTR_BASE, ATTR_SIZE);
        bank_hit = in_region(apb.paddr, BANK_BASE, BANK_SIZE);
        gfx_hit  = in_region(apb.paddr, GFX_BASE, GFX_SIZE);
        if (bank_hit) begin
            offset = apb.paddr - BANK_BASE;
        end else if (gfx_hit) begin
            offset = apb.paddr - GFX_BASE;
        end else begin
            offset = apb.paddr - ATTR_BASE;
        end
    end

    // decode is taken in the setup cycle and held through the access
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            attr_sel <= 1'b0;
            bank_sel <= 1'b0;
            gfx_sel  <= 1'b0;
            bad_sel  <= 1'b0;
        end else if (setup) begin
            attr_sel <= attr_hit;
            bank_sel <= bank_hit;
            gfx_sel  <= gfx_hit;
            bad_sel  <= !(attr_hit || bank_hit || gfx_hit);
        end else if (done) begin
            attr_sel <= 1'b0;
            bank_sel <= 1'b0;
            gfx_sel  <= 1'b0;
            bad_sel  <= 1'b0;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (setup) begin
            waddr <= offset[15:0];
            wdata <= apb.pwdata;
        end
    end

    // attribute table is owned by the copier while it runs
    assign pready  = !(access && attr_sel && copy_busy);
    assign done    = access && pready;
    assign pslverr = done && bad_sel;

    assign attr_we = done && apb.pwrite && attr_sel;
    assign bank_we = done && apb.pwrite && bank_sel;
    assign gfx_we  = done && apb.pwrite && gfx_sel;

endmodule

`default_nettype wire

// File: bus_pkg.sv
// apb request struct, host address type and host memory map
`default_nettype none

package bus_pkg;

    // host byte address
    typedef logic [16:0] apb_addr_t;

    // one apb request as driven by the host
    typedef struct packed {
        logic       psel;
        logic       penable;
        logic       pwrite;
        apb_addr_t  paddr;
        logic [7:0] pwdata;
    } apb_req_t;

    // ====================
    // host memory map
    // ====================
    // sprite attribute table with 4 bytes per sprite
    localparam apb_addr_t   ATTR_BASE = 17'h00000;
    localparam int unsigned ATTR_SIZE = 256;
    // palette bank table with 4 bits per entry
    localparam apb_addr_t   BANK_BASE = 17'h00100;
    localparam int unsigned BANK_SIZE = 256;
    // sprite graphics rom
    localparam apb_addr_t   GFX_BASE  = 17'h10000;
    localparam int unsigned GFX_SIZE  = 65536;

endpackage

`default_nettype wire

// File: dual_port_ram.sv
// generic ram with one write port and one registered read port
`timescale 1ns/10ps
`default_nettype none

module dual_port_ram #(
    parameter int DEPTH = 256,
    parameter int WIDTH = 8
) (
    input  logic                     clk_sys,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  logic [WIDTH-1:0]         wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output logic [WIDTH-1:0]         rdata
);

    logic [WIDTH-1:0] mem [DEPTH];

    // read data follows the address by one clock
    always_ff @(posedge clk_sys) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

// File: sim.f
bus_pkg.sv
sprite_pkg.sv
dual_port_ram.sv
apb_mem_port.sv
sprite_list_copier.sv
sprite_line_renderer.sv
sprite_engine.sv
tb_sprite_engine.sv

// File: sprite_engine.sv
// top level with the apb port, sprite memories, list copier and line renderer
`timescale 1ns/10ps
`default_nettype none

module sprite_engine #(
    parameter int NUM_SPRITES = 64,
    parameter int LINE_WIDTH  = 256
) (
    input  logic               clk_sys,
    input  logic               reset,
    input  bus_pkg::apb_req_t  apb,
    output logic               pready,
    output logic               pslverr,
    input  logic               vblank,
    output logic               copy_busy,
    input  logic               line_start,
    input  sprite_pkg::line_t  line_num,
    output logic               line_busy,
    input  sprite_pkg::line_t  pix_x,
    output sprite_pkg::pixel_t pix
);
    import sprite_pkg::*;

    localparam int ATTR_AW    = $clog2(NUM_SPRITES * 4);
    localparam int BUF_AW     = $clog2(NUM_SPRITES);
    // one bank entry per tile pair
    localparam int BANK_DEPTH = 2 ** ($bits(tile_t) - 1);
    localparam int BANK_AW    = $clog2(BANK_DEPTH);
    localparam int GFX_DEPTH  = 2 ** 16;

    logic [15:0]        waddr;
    logic [7:0]         wdata;
    logic               attr_we;
    logic               bank_we;
    logic               gfx_we;
    logic [ATTR_AW-1:0] attr_raddr;
    logic [7:0]         attr_rdata;
    logic               buf_we;
    logic [BUF_AW-1:0]  buf_waddr;
    logic [BUF_AW-1:0]  buf_raddr;
    sprite_t            buf_wdata;
    sprite_t            buf_rdata;
    logic [7:0]         bank_raddr;
    logic [3:0]         bank_rdata;
    logic [15:0]        gfx_raddr;
    logic [7:0]         gfx_rdata;
    logic               lb_we;
    line_t              lb_waddr;
    pixel_t             lb_wdata;

    // ====================
    // host side
    // ====================
    apb_mem_port apb_mem_port_i (
        .clk_sys,
        .reset,
        .apb,
        .copy_busy,
        .pready,
        .pslverr,
        .attr_we,
        .bank_we,
        .gfx_we,
        .waddr,
        .wdata
    );

    dual_port_ram #(.DEPTH(NUM_SPRITES * 4), .WIDTH(8)) attr_ram_i (
        .clk_sys,
        .we(attr_we), .waddr(waddr[ATTR_AW-1:0]), .wdata(wdata),
        .raddr(attr_raddr), .rdata(attr_rdata)
    );

    dual_port_ram #(.DEPTH(BANK_DEPTH), .WIDTH(4)) bank_ram_i (
        .clk_sys,
        .we(bank_we), .waddr(waddr[BANK_AW-1:0]), .wdata(wdata[3:0]),
        .raddr(bank_raddr), .rdata(bank_rdata)
    );

    dual_port_ram #(.DEPTH(GFX_DEPTH), .WIDTH(8)) gfx_rom_i (
        .clk_sys,
        .we(gfx_we), .waddr(waddr), .wdata(wdata),
        .raddr(gfx_raddr), .rdata(gfx_rdata)
    );

    // ====================
    // sprite pipeline
    // ====================
    sprite_list_copier #(.NUM_SPRITES(NUM_SPRITES)) sprite_list_copier_i (
        .clk_sys,
        .reset,
        .vblank,
        .attr_raddr,
        .attr_rdata,
        .buf_we,
        .buf_waddr,
        .buf_wdata,
        .copy_busy
    );

    dual_port_ram #(.DEPTH(NUM_SPRITES), .WIDTH($bits(sprite_t))) sprite_buf_i (
        .clk_sys,
        .we(buf_we), .waddr(buf_waddr), .wdata(buf_wdata),
        .raddr(buf_raddr), .rdata(buf_rdata)
    );

    sprite_line_renderer #(
        .NUM_SPRITES(NUM_SPRITES),
        .LINE_WIDTH(LINE_WIDTH)
    ) sprite_line_renderer_i (
        .clk_sys,
        .reset,
        .line_start,
        .line_num,
        .buf_raddr,
        .buf_rdata,
        .bank_raddr,
        .bank_rdata,
        .gfx_raddr,
        .gfx_rdata,
        .lb_we,
        .lb_waddr,
        .lb_wdata,
        .line_busy
    );

    // read port goes straight to the host
    dual_port_ram #(.DEPTH(LINE_WIDTH), .WIDTH($bits(pixel_t))) line_buf_i (
        .clk_sys,
        .we(lb_we), .waddr(lb_waddr), .wdata(lb_wdata),
        .raddr(pix_x), .rdata(pix)
    );

endmodule

`default_nettype wire

// File: sprite_line_renderer.sv
// line clear, then sprite draw into the line buffer
`timescale 1ns/10ps
`default_nettype none

module sprite_line_renderer #(
    parameter int NUM_SPRITES = 64,
    parameter int LINE_WIDTH  = 256
) (
    input  logic                           clk_sys,
    input  logic                           reset,
    input  logic                           line_start,
    input  sprite_pkg::line_t              line_num,
    output logic [$clog2(NUM_SPRITES)-1:0] buf_raddr,
    input  sprite_pkg::sprite_t            buf_rdata,
    output logic [7:0]                     bank_raddr,
    input  logic [3:0]                     bank_rdata,
    output logic [15:0]                    gfx_raddr,
    input  logic [7:0]                     gfx_rdata,
    output logic                           lb_we,
    output sprite_pkg::line_t              lb_waddr,
    output sprite_pkg::pixel_t             lb_wdata,
    output logic                           line_busy
);
    import sprite_pkg::*;

    localparam int IDX_W = $clog2(NUM_SPRITES);

    typedef enum logic [2:0] {
        IDLE,
        CLEAR,
        FETCH,
        DRAW,
        NEXT
    } state_t;

    state_t           state;
    logic [IDX_W-1:0] spr_idx;
    logic             fetch_wait;
    line_t            clr_x;
    logic [4:0]       col;
    line_t            cur_line;
    line_t            row_diff;
    sprite_t          spr;
    logic [3:0]       row;
    logic [3:0]       frow;
    logic [3:0]       fcol;
    logic             p_valid;
    logic [3:0]       p_col;
    logic             p_hi;
    pen_t             pen;
    xpos_t            px;
    logic             draw_pix;

    // ====================
    // control
    // ====================
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            state      <= IDLE;
            spr_idx    <= '0;
            fetch_wait <= 1'b0;
            clr_x      <= '0;
            col        <= '0;
            p_valid    <= 1'b0;
        end else begin
            // a column issued now is written next cycle
            p_valid <= (state == DRAW) && (col < 5'(SPRITE_SIZE));
            case (state)
                IDLE: begin
                    if (line_start) begin
                        clr_x <= '0;
                        state <= CLEAR;
                    end
                end
                CLEAR: begin
                    clr_x <= clr_x + 1'b1;
                    if (clr_x == line_t'(LINE_WIDTH - 1)) begin
                        spr_idx    <= '0;
                        fetch_wait <= 1'b0;
                        state      <= FETCH;
                    end
                end
                FETCH: begin
                    // first cycle waits for the buffer read
                    fetch_wait <= 1'b1;
                    if (fetch_wait) begin
                        fetch_wait <= 1'b0;
                        col        <= '0;
                        if (row_diff < line_t'(SPRITE_SIZE)) begin
                            state <= DRAW;
                        end else begin
                            state <= NEXT;
                        end
                    end
                end
                DRAW: begin
                    col <= col + 1'b1;
                    if (col == 5'(SPRITE_SIZE)) begin
                        state <= NEXT;
                    end
                end
                NEXT: begin
                    if (spr_idx == IDX_W'(NUM_SPRITES - 1)) begin
                        state <= IDLE;
                    end else begin
                        spr_idx <= spr_idx + 1'b1;
                        state   <= FETCH;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_sys) begin
        if (state == IDLE && line_start) begin
            cur_line <= line_num;
        end
        if (state == FETCH && fetch_wait) begin
            spr <= buf_rdata;
            row <= row_diff[3:0];
        end
        p_col <= col[3:0];
        p_hi  <= fcol[0];
    end

    // ====================
    // graphics addressing
    // ====================
    assign row_diff = cur_line - buf_rdata.y;
    assign fcol     = spr.flip_x ? 4'(SPRITE_SIZE - 1) - col[3:0] : col[3:0];
    assign frow     = spr.flip_y ? 4'(SPRITE_SIZE - 1) - row : row;

    assign buf_raddr  = spr_idx;
    assign gfx_raddr  = {fcol[1], spr.tile, frow, fcol[3:2]};
    // two tiles share one palette bank entry
    assign bank_raddr = spr.tile[8:1];

    // pixel write lags the address by one cycle
    assign pen      = p_hi ? gfx_rdata[7:4] : gfx_rdata[3:0];
    assign px       = spr.x + xpos_t'(p_col);
    assign draw_pix = p_valid && (px < LINE_WIDTH) && (pen != TRANSPARENT_PEN);

    assign lb_we     = (state == CLEAR) || draw_pix;
    assign lb_waddr  = (state == CLEAR) ? clr_x : line_t'(px[7:0]);
    assign lb_wdata  = (state == CLEAR) ? '0 : {bank_rdata, spr.colour, pen};
    assign line_busy = (state != IDLE);

endmodule

`default_nettype wire

// File: sprite_list_copier.sv
// vblank copy of the attribute table into the sprite buffer, with attribute decode
`timescale 1ns/10ps
`default_nettype none

module sprite_list_copier #(
    parameter int NUM_SPRITES = 64
) (
    input  logic                             clk_sys,
    input  logic                             reset,
    input  logic                             vblank,
    output logic [$clog2(NUM_SPRITES*4)-1:0] attr_raddr,
    input  logic [7:0]                       attr_rdata,
    output logic                             buf_we,
    output logic [$clog2(NUM_SPRITES)-1:0]   buf_waddr,
    output sprite_pkg::sprite_t              buf_wdata,
    output logic                             copy_busy
);
    import sprite_pkg::*;

    localparam int IDX_W = $clog2(NUM_SPRITES);

    // one sprite takes the eight states from RD_B0 to NEXT
    typedef enum logic [3:0] {
        IDLE,
        RD_B0,
        RD_B1,
        RD_B2,
        RD_B3,
        CAP_B3,
        DECODE,
        WRITE,
        NEXT
    } state_t;

    state_t           state;
    logic [IDX_W-1:0] idx;
    logic [1:0]       vblank_sr;
    logic             vblank_rise;
    logic [1:0]       byte_sel;
    logic [7:0]       b0;
    logic [7:0]       b1;
    logic [7:0]       b2;
    logic [7:0]       b3;
    sprite_t          spr;

    assign vblank_rise = vblank_sr[0] && !vblank_sr[1];

    // ====================
    // control
    // ====================
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            state     <= IDLE;
            idx       <= '0;
            vblank_sr <= 2'b00;
        end else begin
            vblank_sr <= {vblank_sr[0], vblank};
            case (state)
                IDLE: begin
                    if (vblank_rise) begin
                        idx   <= '0;
                        state <= RD_B0;
                    end
                end
                RD_B0:  state <= RD_B1;
                RD_B1:  state <= RD_B2;
                RD_B2:  state <= RD_B3;
                RD_B3:  state <= CAP_B3;
                CAP_B3: state <= DECODE;
                DECODE: state <= WRITE;
                WRITE:  state <= NEXT;
                NEXT: begin
                    if (idx == IDX_W'(NUM_SPRITES - 1)) begin
                        state <= IDLE;
                    end else begin
                        idx   <= idx + 1'b1;
                        state <= RD_B0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // byte address leads the capture by one state
    always_comb begin
        case (state)
            RD_B1:   byte_sel = 2'd1;
            RD_B2:   byte_sel = 2'd2;
            RD_B3:   byte_sel = 2'd3;
            default: byte_sel = 2'd0;
        endcase
    end

    assign attr_raddr = {idx, byte_sel};

    // ====================
    // byte capture and decode
    // ====================
    always_ff @(posedge clk_sys) begin
        case (state)
            RD_B1:  b0 <= attr_rdata;
            RD_B2:  b1 <= attr_rdata;
            RD_B3:  b2 <= attr_rdata;
            CAP_B3: b3 <= attr_rdata;
            DECODE: begin
                spr.y      <= Y_ORIGIN - b0;
                spr.tile   <= {b2[1], b1};
                // bit 0 of b2 extends x to nine bits
                spr.x      <= {b2[0], b3} - X_ORIGIN;
                spr.flip_x <= b2[2];
                spr.flip_y <= b2[3];
                spr.colour <= b2[7:4];
            end
            default: begin
            end
        endcase
    end

    assign buf_we    = (state == WRITE);
    assign buf_waddr = idx;
    assign buf_wdata = spr;
    assign copy_busy = (state != IDLE);

endmodule

`default_nettype wire

// File: sprite_pkg.sv
// sprite geometry, tile, pen and pixel types, decoded sprite struct, sprite format constants
`default_nettype none

package sprite_pkg;

    // scanline or x position on the line
    typedef logic [7:0]  line_t;
    // sprite x, wraps at 512
    typedef logic [8:0]  xpos_t;
    typedef logic [8:0]  tile_t;
    // pen 0 is see-through
    typedef logic [3:0]  pen_t;
    typedef logic [3:0]  colour_t;
    // line buffer entry holds bank, colour and pen
    typedef logic [11:0] pixel_t;

    // one entry of the sprite buffer after decode
    typedef struct packed {
        tile_t   tile;
        xpos_t   x;
        line_t   y;
        colour_t colour;
        logic    flip_x;
        logic    flip_y;
    } sprite_t;

    // ====================
    // sprite format
    // ====================
    localparam int    SPRITE_SIZE     = 16;
    // raw y is counted up from the bottom of the screen
    localparam line_t Y_ORIGIN        = 8'd240;
    localparam xpos_t X_ORIGIN        = 9'd128;
    localparam pen_t  TRANSPARENT_PEN = 4'd0;

endpackage

`default_nettype wire

// File: sprite_tests.txt
# cmd: T name | Z | W/E/S hex_addr hex_data | V | R line | P x hex_pixel | K x_first x_last hex_pixel
# line and x are decimal; a pixel is bank, colour and pen as three hex digits
T load_and_error
Z
# tile 105 row 2, pen equals column
W 14148 10
W 14149 54
W 1414a 98
W 1414b dc
W 1c148 32
W 1c149 76
W 1c14a ba
W 1c14b fe
# tile 105 row 13, pen is column plus 8
W 14174 98
W 14175 dc
W 14176 10
W 14177 54
W 1c174 ba
W 1c175 fe
W 1c176 32
W 1c177 76
# tile 006 row 5, odd columns pen 9
W 10194 90
W 10195 90
W 10196 90
W 10197 90
W 18194 90
W 18195 90
W 18196 90
W 18197 90
W 00182 07
W 00103 03
E 00200 55
E 0ffff aa
# sprite 0: tile 105, y 98, x 40, colour 5
W 00000 8e
W 00001 05
W 00002 52
W 00003 a8
T placement
V
R 100
P 40 000
P 41 751
P 47 757
P 50 75a
P 55 75f
K 0 39 000
K 56 255 000
T flip_x
W 00002 56
V
R 100
P 40 75f
P 45 75a
P 54 751
P 55 000
T flip_y
W 00002 5a
V
R 100
P 40 758
P 47 75f
P 48 000
P 55 757
T priority
W 00002 52
# sprite 1: tile 006, y 95, x 48, colour c
W 00004 91
W 00005 06
W 00006 c0
W 00007 b0
V
R 100
P 47 757
P 48 758
P 49 3c9
P 54 75e
P 55 3c9
P 56 000
P 63 3c9
P 64 000
T empty_line
R 90
K 0 255 000
T clipping
W 00002 53
W 00003 7a
V
R 100
K 0 47 000
K 64 249 000
P 250 000
P 251 751
P 255 755
T stalled_write
S 00000 7a
R 120
K 0 255 000
V
R 120
K 0 249 000
P 251 751
P 255 755
R 100
P 47 000
P 49 3c9

// File: tb_sprite_engine.sv
// testbench with clock, reset, apb driver, vblank and line control and test file replay
`timescale 1ns/10ps
`default_nettype none

module tb_sprite_engine;
    import bus_pkg::*;
    import sprite_pkg::*;

    localparam int          CLK_PERIOD   = 10;
    localparam int          RESET_CYCLES = 10;
    // outputs are read this long after the falling edge
    localparam int          SAMPLE_DELAY = 2;
    localparam int          APB_TIMEOUT  = 2000;
    localparam int          COPY_TIMEOUT = 2000;
    localparam int          LINE_TIMEOUT = 5000;
    localparam logic [31:0] SEED         = 32'hf559_9aae;

    logic     clk_sys;
    logic     reset;
    apb_req_t apb;
    logic     pready;
    logic     pslverr;
    logic     vblank;
    logic     copy_busy;
    logic     line_start;
    line_t    line_num;
    logic     line_busy;
    line_t    pix_x;
    pixel_t   pix;

    logic [8*32-1:0] test_name;

    sprite_engine sprite_engine_i (
        .clk_sys,
        .reset,
        .apb,
        .pready,
        .pslverr,
        .vblank,
        .copy_busy,
        .line_start,
        .line_num,
        .line_busy,
        .pix_x,
        .pix
    );

    initial begin
        clk_sys = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
        end
    end

    // ====================
    // failure and checks
    // ====================
    task automatic stop_run();
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch in test %0s: expected 0x%0h, actual 0x%0h",
                     test_name, expected, actual);
            stop_run();
        end
    endtask

    // ====================
    // waits
    // ====================
    task automatic wait_copy_busy(input logic level);
        int cycles;
        cycles = 0;
        while (copy_busy !== level) begin
            @(negedge clk_sys);
            cycles++;
            if (cycles > COPY_TIMEOUT) begin
                $display("timeout: copy_busy did not go to %0b", level);
                stop_run();
            end
        end
    endtask

    task automatic wait_line_busy(input logic level);
        int cycles;
        cycles = 0;
        while (line_busy !== level) begin
            @(negedge clk_sys);
            cycles++;
            if (cycles > LINE_TIMEOUT) begin
                $display("timeout: line_busy did not go to %0b", level);
                stop_run();
            end
        end
    endtask

    // ====================
    // bus and control
    // ====================
    task automatic idle_gap();
        int gap;
        gap = $urandom % 4;
        repeat (gap) @(negedge clk_sys);
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data,
                             output logic err, output int stalls);
        logic done;
        stalls = 0;
        done   = 1'b0;
        err    = 1'b0;
        @(negedge clk_sys);
        apb.psel    = 1'b1;
        apb.penable = 1'b0;
        apb.pwrite  = 1'b1;
        apb.paddr   = addr[16:0];
        apb.pwdata  = data[7:0];
        @(negedge clk_sys);
        apb.penable = 1'b1;
        while (!done) begin
            #(SAMPLE_DELAY);
            if (pready === 1'b1) begin
                done = 1'b1;
                err  = pslverr;
            end else begin
                stalls++;
                if (stalls > APB_TIMEOUT) begin
                    $display("timeout: pready stayed low during an apb write");
                    stop_run();
                end
            end
            @(negedge clk_sys);
        end
        apb.psel    = 1'b0;
        apb.penable = 1'b0;
        idle_gap();
    endtask

    // zeroed entries sit at x 384 and stay off the line
    task automatic clear_attributes();
        logic err;
        int   stalls;
        int   i;
        for (i = 0; i < ATTR_SIZE; i++) begin
            apb_write(ATTR_BASE + i, 32'h0, err, stalls);
            check_value(0, err);
        end
    endtask

    task automatic pulse_vblank();
        @(negedge clk_sys);
        vblank = 1'b1;
        wait_copy_busy(1'b1);
        @(negedge clk_sys);
        vblank = 1'b0;
    endtask

    task automatic render_line(input line_t n);
        @(negedge clk_sys);
        line_num   = n;
        line_start = 1'b1;
        @(negedge clk_sys);
        line_start = 1'b0;
        wait_line_busy(1'b1);
        wait_line_busy(1'b0);
    endtask

    task automatic read_pixel(input line_t x, output pixel_t value);
        @(negedge clk_sys);
        pix_x = x;
        @(negedge clk_sys);
        value = pix;
    endtask

    // ====================
    // test file commands
    // ====================
    task automatic run_command(input logic [8*160-1:0] text);
        logic [8*8-1:0] cmd;
        logic [31:0]    a;
        logic [31:0]    b;
        logic [31:0]    c;
        logic           err;
        int             stalls;
        int             fields;
        int             x;
        pixel_t         value;
        cmd    = '0;
        fields = $sscanf(text, "%s", cmd);
        if (fields == 1) begin
            case (cmd)
                "#": begin
                end
                "T": begin
                    test_name = '0;
                    fields = $sscanf(text, "%s %s", cmd, test_name);
                    $display("test %0s", test_name);
                end
                "Z": clear_attributes();
                "W": begin
                    fields = $sscanf(text, "%s %h %h", cmd, a, b);
                    apb_write(a, b, err, stalls);
                    check_value(0, err);
                end
                "E": begin
                    fields = $sscanf(text, "%s %h %h", cmd, a, b);
                    apb_write(a, b, err, stalls);
                    check_value(1, err);
                end
                "S": begin
                    // write lands while the copier owns the table
                    fields = $sscanf(text, "%s %h %h", cmd, a, b);
                    pulse_vblank();
                    apb_write(a, b, err, stalls);
                    check_value(1, stalls > 0);
                    check_value(0, err);
                    // the write may only complete once the copy is over
                    check_value(0, copy_busy);
                end
                "V": begin
                    pulse_vblank();
                    wait_copy_busy(1'b0);
                end
                "R": begin
                    fields = $sscanf(text, "%s %d", cmd, a);
                    render_line(a[7:0]);
                end
                "P": begin
                    fields = $sscanf(text, "%s %d %h", cmd, a, b);
                    read_pixel(a[7:0], value);
                    check_value(b, value);
                end
                "K": begin
                    fields = $sscanf(text, "%s %d %d %h", cmd, a, b, c);
                    for (x = a; x <= b; x++) begin
                        read_pixel(line_t'(x), value);
                        check_value(c, value);
                    end
                end
                default: begin
                    $display("unknown command in sprite_tests.txt: %0s", cmd);
                    stop_run();
                end
            endcase
        end
    endtask

    initial begin
        int               fd;
        int               status;
        int unsigned      seed_value;
        logic [8*160-1:0] text;
        seed_value = $urandom(SEED);
        reset      = 1'b1;
        apb        = '0;
        vblank     = 1'b0;
        line_start = 1'b0;
        line_num   = '0;
        pix_x      = '0;
        test_name  = '0;
        repeat (RESET_CYCLES) @(posedge clk_sys);
        @(negedge clk_sys);
        reset = 1'b0;

        fd = $fopen("sprite_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open sprite_tests.txt");
            stop_run();
        end
        text   = '0;
        status = $fgets(text, fd);
        while (status != 0) begin
            run_command(text);
            text   = '0;
            status = $fgets(text, fd);
        end
        $fclose(fd);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire
